// File: src/br_pkg.sv
/*
 * bridge package
 * shared widths, host register map, command codes and loader FSM states
 */

package br_pkg;

  // bus widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] mem_addr_t;
  typedef logic [3:0]  sel_t;
  typedef logic [2:0]  reg_addr_t;

  // host register map, word indices
  localparam reg_addr_t REG_ADDR   = 3'd0;
  localparam reg_addr_t REG_WDATA  = 3'd1;
  localparam reg_addr_t REG_CMD    = 3'd2;
  localparam reg_addr_t REG_RDATA  = 3'd3;
  localparam reg_addr_t REG_STATUS = 3'd4;

  // command codes written to REG_CMD
  localparam word_t CMD_STORE = 32'd1;
  localparam word_t CMD_LOAD  = 32'd2;

  // reset release delay per region
  localparam int RESET_STAGES = 4;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    DONE
  } loader_state_t;

endpackage : br_pkg

// File: src/br_reset_pipe.sv
/*
 * reset pipe
 * delays the release of reset_i by a fixed number of cycles
 */

module br_reset_pipe (
  input  logic clk_i
  ,input  logic reset_i
  ,output logic reset_o
);

  logic [br_pkg::RESET_STAGES-1:0] pipe_r;

  // assert at once, release through the chain
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pipe_r <= '1;
    end else begin
      pipe_r <= {pipe_r[br_pkg::RESET_STAGES-2:0], 1'b0};
    end
  end

  assign reset_o = pipe_r[br_pkg::RESET_STAGES-1];

endmodule : br_reset_pipe

// File: src/br_loader_bridge.sv
/*
 * loader bridge
 * host register file plus a command engine that issues single word
 * loads and stores to device memory
 */

module br_loader_bridge (
  input  logic              clk_i
  ,input  logic              reset_i
  // host register port
  ,input  logic              reg_cyc_i
  ,input  logic              reg_stb_i
  ,input  logic              reg_we_i
  ,input  br_pkg::reg_addr_t reg_adr_i
  ,input  br_pkg::word_t     reg_dat_i
  ,output br_pkg::word_t     reg_dat_o
  ,output logic              reg_ack_o
  // memory request toward the mux
  ,output logic              ld_cyc_o
  ,output logic              ld_stb_o
  ,output logic              ld_we_o
  ,output br_pkg::mem_addr_t ld_adr_o
  ,output br_pkg::word_t     ld_dat_o
  ,output br_pkg::sel_t      ld_sel_o
  ,input  br_pkg::word_t     ld_rdat_i
  ,input  logic              ld_ack_i
);

  br_pkg::loader_state_t state_r;
  logic                  busy_r;
  logic                  reg_ack_r;
  logic                  reg_fire;
  logic                  cmd_valid;
  logic                  cmd_accept;
  br_pkg::mem_addr_t     addr_r;
  br_pkg::word_t         wdata_r;
  br_pkg::word_t         rdata_r;
  br_pkg::word_t         reg_dat_r;
  br_pkg::word_t         rd_mux;
  br_pkg::mem_addr_t     req_adr_r;
  br_pkg::word_t         req_dat_r;
  logic                  req_we_r;

  // ----------------------------------------
  // host register port
  // ----------------------------------------

  // first cycle of a register access
  assign reg_fire = reg_cyc_i & reg_stb_i & ~reg_ack_r;

  assign cmd_valid  = (reg_dat_i == br_pkg::CMD_STORE) | (reg_dat_i == br_pkg::CMD_LOAD);
  assign cmd_accept = reg_fire & reg_we_i & (reg_adr_i == br_pkg::REG_CMD)
                    & cmd_valid & ~busy_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ack_r <= 1'b0;
    end else begin
      reg_ack_r <= reg_fire;
    end
  end

  always_comb begin
    case (reg_adr_i)
      br_pkg::REG_ADDR:   rd_mux = addr_r;
      br_pkg::REG_WDATA:  rd_mux = wdata_r;
      br_pkg::REG_RDATA:  rd_mux = rdata_r;
      br_pkg::REG_STATUS: rd_mux = {31'b0, busy_r};
      default:            rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reg_fire && reg_we_i) begin
      case (reg_adr_i)
        br_pkg::REG_ADDR:  addr_r <= reg_dat_i;
        br_pkg::REG_WDATA: wdata_r <= reg_dat_i;
        default: ;
      endcase
    end
    if (reg_fire && !reg_we_i) begin
      reg_dat_r <= rd_mux;
    end
    // snapshot so later register writes leave the bus request alone
    if (cmd_accept) begin
      req_adr_r <= addr_r;
      req_dat_r <= wdata_r;
      req_we_r  <= (reg_dat_i == br_pkg::CMD_STORE);
    end
    if (state_r == br_pkg::REQ && ld_ack_i && !req_we_r) begin
      rdata_r <= ld_rdat_i;
    end
  end

  assign reg_ack_o = reg_ack_r;
  assign reg_dat_o = reg_dat_r;

  // ----------------------------------------
  // command engine
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= br_pkg::IDLE;
      busy_r  <= 1'b0;
    end else begin
      if (cmd_accept) begin
        busy_r <= 1'b1;
      end
      case (state_r)
        br_pkg::IDLE: begin
          if (busy_r) begin
            state_r <= br_pkg::REQ;
          end
        end
        br_pkg::REQ: begin
          // wait out the grant and memory wait states
          if (ld_ack_i) begin
            state_r <= br_pkg::DONE;
          end
        end
        br_pkg::DONE: begin
          busy_r  <= 1'b0;
          state_r <= br_pkg::IDLE;
        end
        default: state_r <= br_pkg::IDLE;
      endcase
    end
  end

  assign ld_cyc_o = (state_r == br_pkg::REQ);
  assign ld_stb_o = (state_r == br_pkg::REQ);
  assign ld_we_o  = req_we_r;
  assign ld_adr_o = req_adr_r;
  assign ld_dat_o = req_dat_r;
  // full word only
  assign ld_sel_o = '1;

endmodule : br_loader_bridge

// File: src/br_mem_mux.sv
/*
 * memory mux
 * round-robin arbiter that merges two Wishbone masters onto one memory port
 */

module br_mem_mux (
  input  logic              clk_i
  ,input  logic              reset_i
  // slot 0, loader
  ,input  logic              s0_cyc_i
  ,input  logic              s0_stb_i
  ,input  logic              s0_we_i
  ,input  br_pkg::mem_addr_t s0_adr_i
  ,input  br_pkg::sel_t      s0_sel_i
  ,input  br_pkg::word_t     s0_dat_i
  ,output br_pkg::word_t     s0_dat_o
  ,output logic              s0_ack_o
  // slot 1, host memory port
  ,input  logic              s1_cyc_i
  ,input  logic              s1_stb_i
  ,input  logic              s1_we_i
  ,input  br_pkg::mem_addr_t s1_adr_i
  ,input  br_pkg::sel_t      s1_sel_i
  ,input  br_pkg::word_t     s1_dat_i
  ,output br_pkg::word_t     s1_dat_o
  ,output logic              s1_ack_o
  // memory port
  ,output logic              m_cyc_o
  ,output logic              m_stb_o
  ,output logic              m_we_o
  ,output br_pkg::mem_addr_t m_adr_o
  ,output br_pkg::sel_t      m_sel_o
  ,output br_pkg::word_t     m_dat_o
  ,input  br_pkg::word_t     m_dat_i
  ,input  logic              m_ack_i
);

  logic gnt_v_r;
  logic gnt_sel_r;
  logic last_r;
  logic pick;
  logic sel_cyc;

  // on a tie the slot not served last wins
  assign pick    = (s0_cyc_i & s1_cyc_i) ? ~last_r : s1_cyc_i;
  assign sel_cyc = gnt_sel_r ? s1_cyc_i : s0_cyc_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gnt_v_r   <= 1'b0;
      gnt_sel_r <= 1'b0;
      last_r    <= 1'b1;
    end else if (!gnt_v_r) begin
      if (s0_cyc_i || s1_cyc_i) begin
        gnt_v_r   <= 1'b1;
        gnt_sel_r <= pick;
        last_r    <= pick;
      end
    end else if (!sel_cyc) begin
      // owner ended its cycle
      gnt_v_r <= 1'b0;
    end
  end

  // ----------------------------------------
  // request and response steering
  // ----------------------------------------
  assign m_cyc_o = gnt_v_r & sel_cyc;
  assign m_stb_o = gnt_v_r & (gnt_sel_r ? s1_stb_i : s0_stb_i);
  assign m_we_o  = gnt_sel_r ? s1_we_i  : s0_we_i;
  assign m_adr_o = gnt_sel_r ? s1_adr_i : s0_adr_i;
  assign m_sel_o = gnt_sel_r ? s1_sel_i : s0_sel_i;
  assign m_dat_o = gnt_sel_r ? s1_dat_i : s0_dat_i;

  assign s0_ack_o = gnt_v_r & ~gnt_sel_r & m_ack_i;
  assign s1_ack_o = gnt_v_r & gnt_sel_r & m_ack_i;
  assign s0_dat_o = (gnt_v_r && !gnt_sel_r) ? m_dat_i : '0;
  assign s1_dat_o = (gnt_v_r && gnt_sel_r) ? m_dat_i : '0;

endmodule : br_mem_mux

// File: src/br_wrapper.sv
/*
 * memory backbone wrapper
 * host register bridge and direct host port merged onto one memory port
 */

module br_wrapper (
  input  logic              clk_i
  ,input  logic              reset_i
  // host register port
  ,input  logic              reg_cyc_i
  ,input  logic              reg_stb_i
  ,input  logic              reg_we_i
  ,input  br_pkg::reg_addr_t reg_adr_i
  ,input  br_pkg::word_t     reg_dat_i
  ,output br_pkg::word_t     reg_dat_o
  ,output logic              reg_ack_o
  // host memory port
  ,input  logic              hmem_cyc_i
  ,input  logic              hmem_stb_i
  ,input  logic              hmem_we_i
  ,input  br_pkg::mem_addr_t hmem_adr_i
  ,input  br_pkg::sel_t      hmem_sel_i
  ,input  br_pkg::word_t     hmem_dat_i
  ,output br_pkg::word_t     hmem_dat_o
  ,output logic              hmem_ack_o
  // device memory port
  ,output logic              mem_cyc_o
  ,output logic              mem_stb_o
  ,output logic              mem_we_o
  ,output br_pkg::mem_addr_t mem_adr_o
  ,output br_pkg::sel_t      mem_sel_o
  ,output br_pkg::word_t     mem_dat_o
  ,input  br_pkg::word_t     mem_dat_i
  ,input  logic              mem_ack_i
);

  logic              bridge_reset;
  logic              mux_reset;

  logic              ld_cyc;
  logic              ld_stb;
  logic              ld_we;
  br_pkg::mem_addr_t ld_adr;
  br_pkg::word_t     ld_dat;
  br_pkg::sel_t      ld_sel;
  br_pkg::word_t     ld_rdat;
  logic              ld_ack;

  // ----------------------------------------
  // per-region reset release
  // ----------------------------------------
  br_reset_pipe bridge_reset_pipe (
    .clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.reset_o (bridge_reset)
  );

  br_reset_pipe mux_reset_pipe (
    .clk_i   (clk_i)
    ,.reset_i (reset_i)
    ,.reset_o (mux_reset)
  );

  br_loader_bridge loader (
    .clk_i     (clk_i)
    ,.reset_i   (bridge_reset)
    ,.reg_cyc_i (reg_cyc_i)
    ,.reg_stb_i (reg_stb_i)
    ,.reg_we_i  (reg_we_i)
    ,.reg_adr_i (reg_adr_i)
    ,.reg_dat_i (reg_dat_i)
    ,.reg_dat_o (reg_dat_o)
    ,.reg_ack_o (reg_ack_o)
    ,.ld_cyc_o  (ld_cyc)
    ,.ld_stb_o  (ld_stb)
    ,.ld_we_o   (ld_we)
    ,.ld_adr_o  (ld_adr)
    ,.ld_dat_o  (ld_dat)
    ,.ld_sel_o  (ld_sel)
    ,.ld_rdat_i (ld_rdat)
    ,.ld_ack_i  (ld_ack)
  );

  // loader on slot 0, host memory on slot 1
  br_mem_mux mem_mux (
    .clk_i    (clk_i)
    ,.reset_i  (mux_reset)
    ,.s0_cyc_i (ld_cyc)
    ,.s0_stb_i (ld_stb)
    ,.s0_we_i  (ld_we)
    ,.s0_adr_i (ld_adr)
    ,.s0_sel_i (ld_sel)
    ,.s0_dat_i (ld_dat)
    ,.s0_dat_o (ld_rdat)
    ,.s0_ack_o (ld_ack)
    ,.s1_cyc_i (hmem_cyc_i)
    ,.s1_stb_i (hmem_stb_i)
    ,.s1_we_i  (hmem_we_i)
    ,.s1_adr_i (hmem_adr_i)
    ,.s1_sel_i (hmem_sel_i)
    ,.s1_dat_i (hmem_dat_i)
    ,.s1_dat_o (hmem_dat_o)
    ,.s1_ack_o (hmem_ack_o)
    ,.m_cyc_o  (mem_cyc_o)
    ,.m_stb_o  (mem_stb_o)
    ,.m_we_o   (mem_we_o)
    ,.m_adr_o  (mem_adr_o)
    ,.m_sel_o  (mem_sel_o)
    ,.m_dat_o  (mem_dat_o)
    ,.m_dat_i  (mem_dat_i)
    ,.m_ack_i  (mem_ack_i)
  );

endmodule : br_wrapper

// File: sim/br_mux_chk.sv
/*
 * mux checker
 * handshake assertions bound into the memory mux
 */

module br_mux_chk (
  input  logic              clk_i
  ,input  logic              reset_i
  ,input  logic              s0_cyc_i
  ,input  logic              s0_stb_i
  ,input  logic              s0_ack_i
  ,input  logic              s1_cyc_i
  ,input  logic              s1_stb_i
  ,input  logic              s1_ack_i
  ,input  logic              mem_cyc_i
  ,input  logic              mem_stb_i
  ,input  logic              mem_we_i
  ,input  br_pkg::mem_addr_t mem_adr_i
  ,input  br_pkg::sel_t      mem_sel_i
  ,input  br_pkg::word_t     mem_dat_i
  ,input  logic              mem_ack_i
);

  int unsigned fail_count = 0;

  stb_has_cyc_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (!s0_stb_i || s0_cyc_i) && (!s1_stb_i || s1_cyc_i) && (!mem_stb_i || mem_cyc_i))
    else begin
      fail_count++;
      $error("strobe without cycle");
    end

  // request held until the memory acks
  mem_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (mem_cyc_i && mem_stb_i && !mem_ack_i) |=> (mem_cyc_i && mem_stb_i && $stable(mem_we_i)
      && $stable(mem_adr_i) && $stable(mem_sel_i) && $stable(mem_dat_i)))
    else begin
      fail_count++;
      $error("memory request changed before ack");
    end

  ack_own_cyc_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (!s0_ack_i || s0_cyc_i) && (!s1_ack_i || s1_cyc_i))
    else begin
      fail_count++;
      $error("slot ack without its cycle");
    end

endmodule : br_mux_chk

bind br_mem_mux br_mux_chk mux_chk (
  .clk_i     (clk_i)
  ,.reset_i   (reset_i)
  ,.s0_cyc_i  (s0_cyc_i)
  ,.s0_stb_i  (s0_stb_i)
  ,.s0_ack_i  (s0_ack_o)
  ,.s1_cyc_i  (s1_cyc_i)
  ,.s1_stb_i  (s1_stb_i)
  ,.s1_ack_i  (s1_ack_o)
  ,.mem_cyc_i (m_cyc_o)
  ,.mem_stb_i (m_stb_o)
  ,.mem_we_i  (m_we_o)
  ,.mem_adr_i (m_adr_o)
  ,.mem_sel_i (m_sel_o)
  ,.mem_dat_i (m_dat_o)
  ,.mem_ack_i (m_ack_i)
);

// File: sim/br_wrapper_tb.sv
/*
 * testbench for the memory backbone wrapper
 * drives the register and host memory ports against a wait-state memory model
 */

module br_wrapper_tb;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int POLL_LIMIT     = 50;

  logic              clk_i;
  logic              reset_i    = 1'b1;
  logic              reg_cyc_i  = 1'b0;
  logic              reg_stb_i  = 1'b0;
  logic              reg_we_i   = 1'b0;
  br_pkg::reg_addr_t reg_adr_i  = '0;
  br_pkg::word_t     reg_dat_i  = '0;
  br_pkg::word_t     reg_dat_o;
  logic              reg_ack_o;
  logic              hmem_cyc_i = 1'b0;
  logic              hmem_stb_i = 1'b0;
  logic              hmem_we_i  = 1'b0;
  br_pkg::mem_addr_t hmem_adr_i = '0;
  br_pkg::sel_t      hmem_sel_i = '0;
  br_pkg::word_t     hmem_dat_i = '0;
  br_pkg::word_t     hmem_dat_o;
  logic              hmem_ack_o;
  logic              mem_cyc_o;
  logic              mem_stb_o;
  logic              mem_we_o;
  br_pkg::mem_addr_t mem_adr_o;
  br_pkg::sel_t      mem_sel_o;
  br_pkg::word_t     mem_dat_o;
  br_pkg::word_t     mem_dat_i  = '0;
  logic              mem_ack_i  = 1'b0;

  br_pkg::word_t     mem_model [br_pkg::mem_addr_t];
  br_pkg::word_t     exp_mem [br_pkg::mem_addr_t];
  br_pkg::word_t     read_exp_q [$];
  int                access_count = 0;
  int                wait_left    = 0;
  int                byte_i;
  logic              in_access    = 1'b0;
  br_pkg::word_t     cur_word;

  br_wrapper dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // reference model helpers
  // ----------------------------------------
  function automatic br_pkg::word_t fill_word(input br_pkg::mem_addr_t adr);
    return adr ^ 32'h5a5a_c3c3;
  endfunction

  // old word with the enabled byte lanes replaced
  function automatic br_pkg::word_t merge_word(input br_pkg::word_t old_w,
                                               input br_pkg::word_t new_w,
                                               input br_pkg::sel_t sel);
    br_pkg::word_t mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic br_pkg::word_t expected_word(input br_pkg::mem_addr_t adr);
    if (exp_mem.exists(adr)) begin
      return exp_mem[adr];
    end
    return fill_word(adr);
  endfunction

  function automatic br_pkg::mem_addr_t host_addr(input int unsigned idx);
    return 32'h0000_1000 + (idx << 2);
  endfunction

  task automatic check_value(input br_pkg::word_t got, input br_pkg::word_t want,
                             input string what);
    if (got !== want) begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, got, want);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // ----------------------------------------
  // memory model, 0 to 3 wait states
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (reset_i) begin
      mem_ack_i <= 1'b0;
      in_access = 1'b0;
    end else if (mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end else if (mem_cyc_o && mem_stb_o) begin
      if (!in_access) begin
        in_access = 1'b1;
        wait_left = int'($urandom_range(3, 0));
      end
      if (wait_left == 0) begin
        cur_word = mem_model.exists(mem_adr_o) ? mem_model[mem_adr_o] : fill_word(mem_adr_o);
        if (mem_we_o) begin
          for (byte_i = 0; byte_i < 4; byte_i++) begin
            if (mem_sel_o[byte_i]) begin
              cur_word[8*byte_i +: 8] = mem_dat_o[8*byte_i +: 8];
            end
          end
          mem_model[mem_adr_o] = cur_word;
        end
        mem_dat_i    <= cur_word;
        mem_ack_i    <= 1'b1;
        access_count <= access_count + 1;
        in_access = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // host read data against the expected queue
  always @(posedge clk_i) begin
    if (hmem_ack_o && !hmem_we_i) begin
      if (read_exp_q.size() == 0) begin
        abort_run("host read acknowledged with no read outstanding");
      end else begin
        check_value(hmem_dat_o, read_exp_q.pop_front(), "host memory read");
      end
    end
  end

  // mux handshake assertions
  always @(posedge clk_i) begin
    if (dut.mem_mux.mux_chk.fail_count != 0) begin
      abort_run("mux handshake assertion failed");
    end
  end

  // ----------------------------------------
  // bus tasks
  // ----------------------------------------
  task automatic reg_access(input logic we, input br_pkg::reg_addr_t adr,
                            input br_pkg::word_t wdat, output br_pkg::word_t rdat);
    int n;
    reg_cyc_i <= 1'b1;
    reg_stb_i <= 1'b1;
    reg_we_i  <= we;
    reg_adr_i <= adr;
    reg_dat_i <= wdat;
    n = 1;
    @(posedge clk_i);
    while (!reg_ack_o && n < TIMEOUT_CYCLES) begin
      n++;
      @(posedge clk_i);
    end
    if (!reg_ack_o) begin
      abort_run("register access was never acknowledged");
    end else begin
      check_value(br_pkg::word_t'(n), 32'd2, "register ack latency");
      rdat = reg_dat_o;
      reg_cyc_i <= 1'b0;
      reg_stb_i <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  task automatic reg_write(input br_pkg::reg_addr_t adr, input br_pkg::word_t wdat);
    br_pkg::word_t unused;
    reg_access(1'b1, adr, wdat, unused);
  endtask

  task automatic reg_read(input br_pkg::reg_addr_t adr, output br_pkg::word_t rdat);
    reg_access(1'b0, adr, '0, rdat);
  endtask

  task automatic wait_loader_idle();
    br_pkg::word_t status;
    int polls;
    polls = 0;
    reg_read(br_pkg::REG_STATUS, status);
    while (status[0] && polls < POLL_LIMIT) begin
      polls++;
      reg_read(br_pkg::REG_STATUS, status);
    end
    if (status[0]) begin
      abort_run("loader stayed busy");
    end
  endtask

  task automatic run_loader(input br_pkg::mem_addr_t adr, input br_pkg::word_t dat,
                            input br_pkg::word_t cmd);
    reg_write(br_pkg::REG_ADDR, adr);
    reg_write(br_pkg::REG_WDATA, dat);
    if (cmd == br_pkg::CMD_STORE) begin
      exp_mem[adr] = merge_word(expected_word(adr), dat, 4'hf);
    end
    reg_write(br_pkg::REG_CMD, cmd);
    wait_loader_idle();
  endtask

  task automatic host_access(input logic we, input br_pkg::mem_addr_t adr,
                             input br_pkg::sel_t sel, input br_pkg::word_t dat);
    int n;
    hmem_cyc_i <= 1'b1;
    hmem_stb_i <= 1'b1;
    hmem_we_i  <= we;
    hmem_adr_i <= adr;
    hmem_sel_i <= sel;
    hmem_dat_i <= dat;
    n = 0;
    @(posedge clk_i);
    while (!hmem_ack_o && n < TIMEOUT_CYCLES) begin
      n++;
      @(posedge clk_i);
    end
    if (!hmem_ack_o) begin
      abort_run("host memory access was never acknowledged");
    end else begin
      hmem_cyc_i <= 1'b0;
      hmem_stb_i <= 1'b0;
      hmem_we_i  <= 1'b0;
      @(posedge clk_i);
    end
  endtask

  task automatic host_write(input br_pkg::mem_addr_t adr, input br_pkg::sel_t sel,
                            input br_pkg::word_t dat);
    exp_mem[adr] = merge_word(expected_word(adr), dat, sel);
    host_access(1'b1, adr, sel, dat);
  endtask

  task automatic host_read(input br_pkg::mem_addr_t adr);
    read_exp_q.push_back(expected_word(adr));
    host_access(1'b0, adr, 4'hf, '0);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    br_pkg::word_t rdat;
    int            idx;
    int            count_before;
    void'($urandom(32'h514));
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    check_value({28'b0, reg_ack_o, hmem_ack_o, mem_cyc_o, mem_stb_o}, '0, "outputs after reset");

    // register readback
    reg_write(br_pkg::REG_ADDR, 32'h0000_2040);
    reg_write(br_pkg::REG_WDATA, 32'hcafe_0001);
    reg_write(br_pkg::REG_STATUS, 32'hffff_ffff);
    reg_read(br_pkg::REG_ADDR, rdat);
    check_value(rdat, 32'h0000_2040, "ADDR readback");
    reg_read(br_pkg::REG_WDATA, rdat);
    check_value(rdat, 32'hcafe_0001, "WDATA readback");
    reg_read(br_pkg::REG_STATUS, rdat);
    check_value(rdat, '0, "STATUS when idle");
    reg_read(br_pkg::REG_CMD, rdat);
    check_value(rdat, '0, "CMD index read");
    for (idx = 5; idx < 8; idx++) begin
      reg_read(br_pkg::reg_addr_t'(idx), rdat);
      check_value(rdat, '0, "undefined register index");
    end

    // loader store
    count_before = access_count;
    run_loader(32'h0000_2000, 32'h1234_5678, br_pkg::CMD_STORE);
    check_value(mem_model[32'h0000_2000], 32'h1234_5678, "word after loader store");
    check_value(br_pkg::word_t'(access_count - count_before), 32'd1, "accesses per store");

    // loader load of a word seeded through the host port
    host_write(32'h0000_2010, 4'hf, 32'h9abc_def0);
    run_loader(32'h0000_2010, '0, br_pkg::CMD_LOAD);
    reg_read(br_pkg::REG_RDATA, rdat);
    check_value(rdat, 32'h9abc_def0, "RDATA after load");
    reg_write(br_pkg::REG_RDATA, 32'h0000_0000);
    reg_read(br_pkg::REG_RDATA, rdat);
    check_value(rdat, 32'h9abc_def0, "RDATA after ignored write");

    // host direct writes with random lanes
    repeat (16) begin
      host_write(host_addr($urandom_range(7, 0)), br_pkg::sel_t'($urandom_range(15, 1)),
                 $urandom);
    end
    for (idx = 0; idx < 8; idx++) begin
      host_read(host_addr(idx));
    end

    // loader and host memory traffic at once, disjoint address ranges
    fork
      begin : host_side
        repeat (12) begin
          host_write(host_addr($urandom_range(7, 0)), br_pkg::sel_t'($urandom_range(15, 1)),
                     $urandom);
          host_read(host_addr($urandom_range(7, 0)));
        end
      end
      begin : loader_side
        br_pkg::word_t     lrdat;
        br_pkg::mem_addr_t ladr;
        ladr = 32'h0000_2100;
        repeat (4) begin
          run_loader(ladr, $urandom, br_pkg::CMD_STORE);
          run_loader(ladr, '0, br_pkg::CMD_LOAD);
          reg_read(br_pkg::REG_RDATA, lrdat);
          check_value(lrdat, expected_word(ladr), "RDATA under host traffic");
          ladr = ladr + 4;
        end
      end
    join

    // second CMD lands while the first store is in flight
    count_before = access_count;
    reg_write(br_pkg::REG_ADDR, 32'h0000_2200);
    reg_write(br_pkg::REG_WDATA, 32'h0bad_f00d);
    exp_mem[32'h0000_2200] = 32'h0bad_f00d;
    reg_write(br_pkg::REG_CMD, br_pkg::CMD_STORE);
    reg_write(br_pkg::REG_CMD, br_pkg::CMD_LOAD);
    wait_loader_idle();
    check_value(br_pkg::word_t'(access_count - count_before), 32'd1, "CMD while busy");

    foreach (exp_mem[a]) begin
      check_value(mem_model.exists(a) ? mem_model[a] : fill_word(a), exp_mem[a],
                  "final memory word");
    end
    check_value(br_pkg::word_t'(read_exp_q.size()), '0, "host reads left unchecked");

    if (dut.mem_mux.mux_chk.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("mux handshake assertion failed");
    end
  end

endmodule : br_wrapper_tb

// File: verilog.f
src/br_pkg.sv
src/br_reset_pipe.sv
src/br_loader_bridge.sv
src/br_mem_mux.sv
src/br_wrapper.sv
sim/br_mux_chk.sv
sim/br_wrapper_tb.sv

// File: Makefile
# Verilator build, run and lint for the memory backbone wrapper

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module br_wrapper_tb \
		-Mdir obj_dir -o sim_br

run: build
	./obj_dir/sim_br | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module br_wrapper_tb

clean:
	rm -rf obj_dir sim.log
